// File: design/rv32i_pkg.sv
`default_nettype none

package rv32i_pkg;

    // basic data and address word
    typedef logic [31:0] word_t;

    // architectural register index
    typedef logic [4:0] reg_idx_t;

    // x0 included, x0 reads as zero
    localparam int NUM_REGS = 32;

    // major opcodes of the supported subset
    localparam logic [6:0] OP_REG   = 7'b0110011;
    localparam logic [6:0] OP_IMM   = 7'b0010011;
    localparam logic [6:0] OP_LUI   = 7'b0110111;
    localparam logic [6:0] OP_LOAD  = 7'b0000011;
    localparam logic [6:0] OP_STORE = 7'b0100011;

    // funct3 for register and immediate ALU ops
    localparam logic [2:0] F3_ADD  = 3'b000;
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    // SRL or SRA, told apart by instr[30]
    localparam logic [2:0] F3_SR   = 3'b101;
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;

    // ALU_ADD must stay zero, an all-zero control word is a bubble
    typedef enum logic [3:0] {
        ALU_ADD    = 4'd0,
        ALU_SUB    = 4'd1,
        ALU_SLL    = 4'd2,
        ALU_SLT    = 4'd3,
        ALU_SLTU   = 4'd4,
        ALU_XOR    = 4'd5,
        ALU_SRL    = 4'd6,
        ALU_SRA    = 4'd7,
        ALU_OR     = 4'd8,
        ALU_AND    = 4'd9,
        ALU_PASS_B = 4'd10
    } alu_op_t;

endpackage

`default_nettype wire

// File: design/pipe_pkg.sv
`default_nettype none

package pipe_pkg;

    // per-instruction control, all zero means bubble
    typedef struct packed {
        rv32i_pkg::alu_op_t alu_op;
        logic               use_imm;
        logic               mem_read;
        logic               mem_write;
        logic               reg_write;
    } ctrl_t;

    // operand source in execute
    typedef enum logic [1:0] {
        FWD_REG    = 2'd0,
        FWD_EX_MEM = 2'd1,
        FWD_MEM_WB = 2'd2
    } fwd_sel_t;

    // decode to execute
    typedef struct packed {
        ctrl_t               ctrl;
        rv32i_pkg::reg_idx_t rs1;
        rv32i_pkg::reg_idx_t rs2;
        rv32i_pkg::reg_idx_t rd;
        rv32i_pkg::word_t    rs1_val;
        rv32i_pkg::word_t    rs2_val;
        rv32i_pkg::word_t    imm;
    } id_ex_t;

    // execute to memory
    typedef struct packed {
        ctrl_t               ctrl;
        rv32i_pkg::reg_idx_t rd;
        rv32i_pkg::word_t    alu_result;
        rv32i_pkg::word_t    store_data;
    } ex_mem_t;

endpackage

`default_nettype wire

// File: design/bypass_if.sv
`timescale 1ns/10ps
`default_nettype none

interface bypass_if;

    // instruction in memory stage
    rv32i_pkg::reg_idx_t ex_mem_rd;
    logic                ex_mem_we;
    rv32i_pkg::word_t    ex_mem_result;

    // instruction in writeback
    rv32i_pkg::reg_idx_t mem_wb_rd;
    logic                mem_wb_we;
    rv32i_pkg::word_t    mem_wb_result;

    modport mem_side (output ex_mem_rd, output ex_mem_we, output ex_mem_result);

    modport wb_side (output mem_wb_rd, output mem_wb_we, output mem_wb_result);

    modport ex_side (
        input ex_mem_rd, input ex_mem_we, input ex_mem_result,
        input mem_wb_rd, input mem_wb_we, input mem_wb_result
    );

endinterface

`default_nettype wire

// File: design/reg_file.sv
`timescale 1ns/10ps
`default_nettype none

module reg_file (
    input  logic                clk,
    input  rv32i_pkg::reg_idx_t rs1_i,
    input  rv32i_pkg::reg_idx_t rs2_i,
    input  logic                we_i,
    input  rv32i_pkg::reg_idx_t rd_i,
    input  rv32i_pkg::word_t    wdata_i,
    output rv32i_pkg::word_t    rs1_val_o,
    output rv32i_pkg::word_t    rs2_val_o
);

    // no storage for x0
    rv32i_pkg::word_t regs_q [1:rv32i_pkg::NUM_REGS-1];

    // x0 zero, same-cycle write passes straight through
    function automatic rv32i_pkg::word_t read_port(input rv32i_pkg::reg_idx_t idx);
        if (idx == '0) begin
            return '0;
        end else if (we_i && (rd_i == idx)) begin
            return wdata_i;
        end
        return regs_q[idx];
    endfunction

    always_ff @(posedge clk) begin
        if (we_i && (rd_i != '0)) begin
            regs_q[rd_i] <= wdata_i;
        end
    end

    always_comb begin
        rs1_val_o = read_port(rs1_i);
        rs2_val_o = read_port(rs2_i);
    end

endmodule

`default_nettype wire

// File: design/fetch_stage.sv
`timescale 1ns/10ps
`default_nettype none

module fetch_stage (
    input  logic             clk,
    input  logic             rst_n_i,
    input  logic             stall_i,
    input  rv32i_pkg::word_t instr_mem_rdata_i,
    output rv32i_pkg::word_t instr_mem_address_o,
    output rv32i_pkg::word_t instr_o
);

    rv32i_pkg::word_t pc_q;
    rv32i_pkg::word_t replay_q;
    logic             replay_sel_q;
    // low until the first fetch has returned
    logic             boot_q;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            pc_q         <= '0;
            replay_sel_q <= 1'b0;
            boot_q       <= 1'b0;
        end else begin
            // pc holds while decode is stalled
            if (!stall_i) begin
                pc_q <= pc_q + 32'd4;
            end
            replay_sel_q <= stall_i;
            boot_q       <= 1'b1;
        end
    end

    // the word returned next cycle belongs to the held pc,
    // so keep the stalled instruction for one more decode
    always_ff @(posedge clk) begin
        if (stall_i) begin
            replay_q <= instr_o;
        end
    end

    assign instr_mem_address_o = pc_q;

    // zero decodes as a bubble
    assign instr_o = !boot_q      ? '0 :
                     replay_sel_q ? replay_q : instr_mem_rdata_i;

endmodule

`default_nettype wire

// File: design/decode_stage.sv
`timescale 1ns/10ps
`default_nettype none

module decode_stage (
    input  logic                clk,
    input  logic                rst_n_i,
    input  rv32i_pkg::word_t    instr_i,
    input  logic                ex_load_i,
    input  rv32i_pkg::reg_idx_t ex_rd_i,
    input  logic                wb_we_i,
    input  rv32i_pkg::reg_idx_t wb_rd_i,
    input  rv32i_pkg::word_t    wb_data_i,
    output logic                stall_o,
    output pipe_pkg::id_ex_t    id_ex_o
);

    logic [6:0]          opcode;
    logic [2:0]          funct3;
    rv32i_pkg::reg_idx_t rs1;
    rv32i_pkg::reg_idx_t rs2;
    rv32i_pkg::reg_idx_t rd;
    rv32i_pkg::word_t    rs1_val;
    rv32i_pkg::word_t    rs2_val;
    rv32i_pkg::word_t    imm;
    pipe_pkg::ctrl_t     ctrl_d;
    logic                uses_rs1;
    logic                uses_rs2;
    pipe_pkg::id_ex_t    id_ex_q;

    // alt selects SUB or SRA
    function automatic rv32i_pkg::alu_op_t alu_sel(input logic [2:0] f3, input logic alt);
        case (f3)
            rv32i_pkg::F3_ADD:  return alt ? rv32i_pkg::ALU_SUB : rv32i_pkg::ALU_ADD;
            rv32i_pkg::F3_SLL:  return rv32i_pkg::ALU_SLL;
            rv32i_pkg::F3_SLT:  return rv32i_pkg::ALU_SLT;
            rv32i_pkg::F3_SLTU: return rv32i_pkg::ALU_SLTU;
            rv32i_pkg::F3_XOR:  return rv32i_pkg::ALU_XOR;
            rv32i_pkg::F3_SR:   return alt ? rv32i_pkg::ALU_SRA : rv32i_pkg::ALU_SRL;
            rv32i_pkg::F3_OR:   return rv32i_pkg::ALU_OR;
            default:            return rv32i_pkg::ALU_AND;
        endcase
    endfunction

    assign opcode = instr_i[6:0];
    assign rd     = instr_i[11:7];
    assign funct3 = instr_i[14:12];
    assign rs1    = instr_i[19:15];
    assign rs2    = instr_i[24:20];

    // writeback port, read-through covers wb to decode
    reg_file reg_file_inst (
        .clk       (clk),
        .rs1_i     (rs1),
        .rs2_i     (rs2),
        .we_i      (wb_we_i),
        .rd_i      (wb_rd_i),
        .wdata_i   (wb_data_i),
        .rs1_val_o (rs1_val),
        .rs2_val_o (rs2_val)
    );

    always_comb begin
        ctrl_d   = '0;
        imm      = '0;
        uses_rs1 = 1'b0;
        uses_rs2 = 1'b0;
        case (opcode)
            rv32i_pkg::OP_REG: begin
                ctrl_d.alu_op    = alu_sel(funct3, instr_i[30]);
                ctrl_d.reg_write = 1'b1;
                uses_rs1         = 1'b1;
                uses_rs2         = 1'b1;
            end
            rv32i_pkg::OP_IMM: begin
                // instr[30] is an immediate bit except for shifts right
                ctrl_d.alu_op    = alu_sel(funct3, instr_i[30] && (funct3 == rv32i_pkg::F3_SR));
                ctrl_d.use_imm   = 1'b1;
                ctrl_d.reg_write = 1'b1;
                imm              = {{20{instr_i[31]}}, instr_i[31:20]};
                uses_rs1         = 1'b1;
            end
            rv32i_pkg::OP_LUI: begin
                ctrl_d.alu_op    = rv32i_pkg::ALU_PASS_B;
                ctrl_d.use_imm   = 1'b1;
                ctrl_d.reg_write = 1'b1;
                imm              = {instr_i[31:12], 12'b0};
            end
            rv32i_pkg::OP_LOAD: begin
                ctrl_d.use_imm   = 1'b1;
                ctrl_d.mem_read  = 1'b1;
                ctrl_d.reg_write = 1'b1;
                imm              = {{20{instr_i[31]}}, instr_i[31:20]};
                uses_rs1         = 1'b1;
            end
            rv32i_pkg::OP_STORE: begin
                ctrl_d.use_imm   = 1'b1;
                ctrl_d.mem_write = 1'b1;
                imm              = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
                uses_rs1         = 1'b1;
                uses_rs2         = 1'b1;
            end
            // anything else stays a bubble
            default: ;
        endcase
    end

    // load in execute feeding this instruction
    assign stall_o = ex_load_i && (ex_rd_i != '0) &&
                     ((uses_rs1 && (rs1 == ex_rd_i)) || (uses_rs2 && (rs2 == ex_rd_i)));

    always_ff @(posedge clk) begin
        // bubble on reset or load-use
        if (!rst_n_i || stall_o) begin
            id_ex_q.ctrl <= '0;
        end else begin
            id_ex_q.ctrl <= ctrl_d;
        end
        id_ex_q.rs1     <= rs1;
        id_ex_q.rs2     <= rs2;
        id_ex_q.rd      <= rd;
        id_ex_q.rs1_val <= rs1_val;
        id_ex_q.rs2_val <= rs2_val;
        id_ex_q.imm     <= imm;
    end

    assign id_ex_o = id_ex_q;

endmodule

`default_nettype wire

// File: design/execute_stage.sv
`timescale 1ns/10ps
`default_nettype none

module execute_stage (
    input  logic                clk,
    input  logic                rst_n_i,
    input  pipe_pkg::id_ex_t    id_ex_i,
    bypass_if.ex_side           byp,
    output logic                ex_load_o,
    output rv32i_pkg::reg_idx_t ex_rd_o,
    output pipe_pkg::ex_mem_t   ex_mem_o
);

    pipe_pkg::fwd_sel_t sel_a;
    pipe_pkg::fwd_sel_t sel_b;
    rv32i_pkg::word_t   rs1_fwd;
    rv32i_pkg::word_t   rs2_fwd;
    rv32i_pkg::word_t   op_b;
    rv32i_pkg::word_t   alu_result;
    pipe_pkg::ex_mem_t  ex_mem_q;

    // younger result wins, never for x0
    function automatic pipe_pkg::fwd_sel_t fwd_pick(
        input rv32i_pkg::reg_idx_t rs,
        input logic                ex_we,
        input rv32i_pkg::reg_idx_t ex_rd,
        input logic                wb_we,
        input rv32i_pkg::reg_idx_t wb_rd
    );
        if (rs == '0) begin
            return pipe_pkg::FWD_REG;
        end else if (ex_we && (ex_rd == rs)) begin
            return pipe_pkg::FWD_EX_MEM;
        end else if (wb_we && (wb_rd == rs)) begin
            return pipe_pkg::FWD_MEM_WB;
        end
        return pipe_pkg::FWD_REG;
    endfunction

    function automatic rv32i_pkg::word_t fwd_mux(
        input pipe_pkg::fwd_sel_t sel,
        input rv32i_pkg::word_t   reg_val,
        input rv32i_pkg::word_t   ex_val,
        input rv32i_pkg::word_t   wb_val
    );
        case (sel)
            pipe_pkg::FWD_EX_MEM: return ex_val;
            pipe_pkg::FWD_MEM_WB: return wb_val;
            default:              return reg_val;
        endcase
    endfunction

    assign sel_a = fwd_pick(id_ex_i.rs1, byp.ex_mem_we, byp.ex_mem_rd,
                            byp.mem_wb_we, byp.mem_wb_rd);
    assign sel_b = fwd_pick(id_ex_i.rs2, byp.ex_mem_we, byp.ex_mem_rd,
                            byp.mem_wb_we, byp.mem_wb_rd);

    assign rs1_fwd = fwd_mux(sel_a, id_ex_i.rs1_val, byp.ex_mem_result, byp.mem_wb_result);
    assign rs2_fwd = fwd_mux(sel_b, id_ex_i.rs2_val, byp.ex_mem_result, byp.mem_wb_result);

    // rs2 still goes on as store data
    assign op_b = id_ex_i.ctrl.use_imm ? id_ex_i.imm : rs2_fwd;

    always_comb begin
        case (id_ex_i.ctrl.alu_op)
            rv32i_pkg::ALU_ADD:    alu_result = rs1_fwd + op_b;
            rv32i_pkg::ALU_SUB:    alu_result = rs1_fwd - op_b;
            rv32i_pkg::ALU_SLL:    alu_result = rs1_fwd << op_b[4:0];
            rv32i_pkg::ALU_SLT:    alu_result = {31'b0, $signed(rs1_fwd) < $signed(op_b)};
            rv32i_pkg::ALU_SLTU:   alu_result = {31'b0, rs1_fwd < op_b};
            rv32i_pkg::ALU_XOR:    alu_result = rs1_fwd ^ op_b;
            rv32i_pkg::ALU_SRL:    alu_result = rs1_fwd >> op_b[4:0];
            rv32i_pkg::ALU_SRA:    alu_result = $signed(rs1_fwd) >>> op_b[4:0];
            rv32i_pkg::ALU_OR:     alu_result = rs1_fwd | op_b;
            rv32i_pkg::ALU_AND:    alu_result = rs1_fwd & op_b;
            rv32i_pkg::ALU_PASS_B: alu_result = op_b;
            default:               alu_result = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            ex_mem_q.ctrl <= '0;
        end else begin
            ex_mem_q.ctrl <= id_ex_i.ctrl;
        end
        ex_mem_q.rd         <= id_ex_i.rd;
        ex_mem_q.alu_result <= alu_result;
        ex_mem_q.store_data <= rs2_fwd;
    end

    // for load-use detection in decode
    assign ex_load_o = id_ex_i.ctrl.mem_read;
    assign ex_rd_o   = id_ex_i.rd;
    assign ex_mem_o  = ex_mem_q;

endmodule

`default_nettype wire

// File: design/mem_wb_stage.sv
`timescale 1ns/10ps
`default_nettype none

module mem_wb_stage (
    input  logic                clk,
    input  logic                rst_n_i,
    input  pipe_pkg::ex_mem_t   ex_mem_i,
    input  rv32i_pkg::word_t    data_mem_rdata_i,
    output rv32i_pkg::word_t    data_mem_address_o,
    output rv32i_pkg::word_t    data_mem_wdata_o,
    output logic                data_read_o,
    output logic                data_write_o,
    output logic                wb_we_o,
    output rv32i_pkg::reg_idx_t wb_rd_o,
    output rv32i_pkg::word_t    wb_data_o,
    bypass_if.mem_side          byp,
    bypass_if.wb_side           byp_wb
);

    pipe_pkg::ctrl_t     ctrl_q;
    rv32i_pkg::reg_idx_t rd_q;
    rv32i_pkg::word_t    result_q;
    rv32i_pkg::word_t    wb_data;

    // word access straight from EX/MEM
    assign data_mem_address_o = ex_mem_i.alu_result;
    assign data_mem_wdata_o   = ex_mem_i.store_data;
    assign data_read_o        = ex_mem_i.ctrl.mem_read;
    assign data_write_o       = ex_mem_i.ctrl.mem_write;

    // load data not back yet, so loads never forward from here
    assign byp.ex_mem_rd     = ex_mem_i.rd;
    assign byp.ex_mem_we     = ex_mem_i.ctrl.reg_write && !ex_mem_i.ctrl.mem_read;
    assign byp.ex_mem_result = ex_mem_i.alu_result;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            ctrl_q <= '0;
        end else begin
            ctrl_q <= ex_mem_i.ctrl;
        end
        rd_q     <= ex_mem_i.rd;
        result_q <= ex_mem_i.alu_result;
    end

    // read data lines up with MEM/WB
    assign wb_data = ctrl_q.mem_read ? data_mem_rdata_i : result_q;

    assign wb_we_o   = ctrl_q.reg_write;
    assign wb_rd_o   = rd_q;
    assign wb_data_o = wb_data;

    assign byp_wb.mem_wb_rd     = rd_q;
    assign byp_wb.mem_wb_we     = ctrl_q.reg_write;
    assign byp_wb.mem_wb_result = wb_data;

endmodule

`default_nettype wire

// File: design/core_top.sv
`timescale 1ns/10ps
`default_nettype none

module core_top (
    input  logic             clk,
    input  logic             rst_n_i,
    input  rv32i_pkg::word_t instr_mem_rdata_i,
    input  rv32i_pkg::word_t data_mem_rdata_i,
    output rv32i_pkg::word_t instr_mem_address_o,
    output rv32i_pkg::word_t data_mem_address_o,
    output rv32i_pkg::word_t data_mem_wdata_o,
    output logic             data_read_o,
    output logic             data_write_o
);

    logic                stall;
    rv32i_pkg::word_t    instr;
    pipe_pkg::id_ex_t    id_ex;
    logic                ex_load;
    rv32i_pkg::reg_idx_t ex_rd;
    pipe_pkg::ex_mem_t   ex_mem;
    // register file write port
    logic                wb_we;
    rv32i_pkg::reg_idx_t wb_rd;
    rv32i_pkg::word_t    wb_data;

    // results of mem and wb back to execute
    bypass_if byp_if ();

    fetch_stage fetch_stage_inst (
        .clk                 (clk),
        .rst_n_i             (rst_n_i),
        .stall_i             (stall),
        .instr_mem_rdata_i   (instr_mem_rdata_i),
        .instr_mem_address_o (instr_mem_address_o),
        .instr_o             (instr)
    );

    decode_stage decode_stage_inst (
        .clk       (clk),
        .rst_n_i   (rst_n_i),
        .instr_i   (instr),
        .ex_load_i (ex_load),
        .ex_rd_i   (ex_rd),
        .wb_we_i   (wb_we),
        .wb_rd_i   (wb_rd),
        .wb_data_i (wb_data),
        .stall_o   (stall),
        .id_ex_o   (id_ex)
    );

    execute_stage execute_stage_inst (
        .clk       (clk),
        .rst_n_i   (rst_n_i),
        .id_ex_i   (id_ex),
        .byp       (byp_if),
        .ex_load_o (ex_load),
        .ex_rd_o   (ex_rd),
        .ex_mem_o  (ex_mem)
    );

    mem_wb_stage mem_wb_stage_inst (
        .clk                (clk),
        .rst_n_i            (rst_n_i),
        .ex_mem_i           (ex_mem),
        .data_mem_rdata_i   (data_mem_rdata_i),
        .data_mem_address_o (data_mem_address_o),
        .data_mem_wdata_o   (data_mem_wdata_o),
        .data_read_o        (data_read_o),
        .data_write_o       (data_write_o),
        .wb_we_o            (wb_we),
        .wb_rd_o            (wb_rd),
        .wb_data_o          (wb_data),
        .byp                (byp_if),
        .byp_wb             (byp_if)
    );

endmodule

`default_nettype wire

// File: verif/core_sva.sv
`timescale 1ns/10ps
`default_nettype none

module core_sva (
    input logic        clk,
    input logic        rst_n_i,
    input logic        data_read_i,
    input logic        data_write_i,
    input logic [31:0] data_mem_address_i
);

    // one data access per cycle at most
    read_write_exclusive: assert property (
        @(posedge clk) disable iff (!rst_n_i) !(data_read_i && data_write_i)
    ) else $error("data read and data write strobes are high in the same cycle");

    // word-only loads and stores
    access_word_aligned: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        (data_read_i || data_write_i) |-> (data_mem_address_i[1:0] == 2'b00)
    ) else $error("data access address is not word aligned");

    // write strobe defined once out of reset
    write_strobe_known: assert property (
        @(posedge clk) rst_n_i |-> !$isunknown(data_write_i)
    ) else $error("data write strobe is unknown after reset");

endmodule

`default_nettype wire

// File: verif/core_tb.sv
`timescale 1ns/10ps
`default_nettype none

module core_tb;

    // setup of x1..x31, random body and final register dump
    localparam int GEN_LEN         = 200;
    localparam int PROG_LEN        = 31 + GEN_LEN + 31;
    localparam int WATCHDOG_CYCLES = (PROG_LEN + 40) * 2;

    logic        clk;
    logic        rst_n_i;
    logic [31:0] instr_mem_rdata_i;
    logic [31:0] data_mem_rdata_i;
    logic [31:0] instr_mem_address_o;
    logic [31:0] data_mem_address_o;
    logic [31:0] data_mem_wdata_o;
    logic        data_read_o;
    logic        data_write_o;

    // memories seen by the DUT
    logic [31:0] imem [0:511];
    logic [31:0] dmem [0:63];
    // reference ISA state
    logic [31:0] mregs [0:31];
    logic [31:0] mmem [0:63];
    // expected store stream with the oldest at the front
    logic [31:0] exp_addr_q [$];
    logic [31:0] exp_data_q [$];
    string       exp_name_q [$];
    logic [31:0] lfsr_state;
    int          stores_total;
    int          stores_seen;

    core_top core_top_inst (
        .clk                 (clk),
        .rst_n_i             (rst_n_i),
        .instr_mem_rdata_i   (instr_mem_rdata_i),
        .data_mem_rdata_i    (data_mem_rdata_i),
        .instr_mem_address_o (instr_mem_address_o),
        .data_mem_address_o  (data_mem_address_o),
        .data_mem_wdata_o    (data_mem_wdata_o),
        .data_read_o         (data_read_o),
        .data_write_o        (data_write_o)
    );

    bind core_top core_sva core_sva_inst (
        .clk                (clk),
        .rst_n_i            (rst_n_i),
        .data_read_i        (data_read_o),
        .data_write_i       (data_write_o),
        .data_mem_address_i (data_mem_address_o)
    );

    always #4 clk = ~clk;

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("TEST FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] act);
        fail_run($sformatf("[FAIL] %s expected %h actual %h", name, exp, act));
    endtask

    // fibonacci lfsr on taps 32 22 2 1 stepped once per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] val;
        logic        fb;
        val = '0;
        for (int k = 0; k < n; k++) begin
            fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            val        = {val[30:0], fb};
        end
        return val;
    endfunction

    // half the picks from x0..x7 so hazards come often
    function automatic logic [4:0] pick_reg();
        logic [31:0] r;
        r = rand_bits(1);
        if (r[0]) begin
            r = rand_bits(3);
        end else begin
            r = rand_bits(5);
        end
        return r[4:0];
    endfunction

    function automatic logic [31:0] fill_word(input logic [31:0] addr);
        return {addr[15:0], addr[31:16]} ^ ~addr ^ 32'hc3a5_0000;
    endfunction

    // RV32I semantics for OP and OP-IMM
    function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] a, input logic [31:0] b);
        logic [4:0] sh;
        sh = b[4:0];
        case (f3)
            3'b000:  return alt ? a - b : a + b;
            3'b001:  return a << sh;
            3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b011:  return (a < b) ? 32'd1 : 32'd0;
            3'b100:  return a ^ b;
            3'b101: begin
                if (alt) begin
                    return $unsigned($signed(a) >>> sh);
                end
                return a >> sh;
            end
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    task automatic init_memories();
        for (int i = 0; i < 512; i++) begin
            imem[i] = '0;
        end
        for (int i = 0; i < 64; i++) begin
            dmem[i] = fill_word(i * 4);
            mmem[i] = fill_word(i * 4);
        end
        for (int i = 0; i < 32; i++) begin
            mregs[i] = '0;
        end
    endtask

    task automatic build_program();
        logic [31:0] r;
        logic [2:0]  kind;
        logic [2:0]  f3;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic        alt;
        logic [11:0] imm12;
        logic [6:0]  f7;
        int          n;
        n = 0;
        // addi xi, x0, imm gives every register a known value
        for (int i = 1; i < 32; i++) begin
            r       = rand_bits(12);
            imem[n] = {r[11:0], 5'd0, 3'b000, 5'(i), 7'b0010011};
            n++;
        end
        for (int i = 0; i < GEN_LEN; i++) begin
            r    = rand_bits(3);
            kind = r[2:0];
            rd   = pick_reg();
            rs1  = pick_reg();
            rs2  = pick_reg();
            r    = rand_bits(3);
            f3   = r[2:0];
            r    = rand_bits(1);
            alt  = r[0];
            case (kind)
                3'd0, 3'd1, 3'd2: begin
                    // sub and sra only where funct7 matters
                    f7      = (alt && (f3 == 3'b000 || f3 == 3'b101)) ? 7'b0100000 : 7'b0;
                    imem[n] = {f7, rs2, rs1, f3, rd, 7'b0110011};
                end
                3'd3, 3'd4: begin
                    r     = rand_bits(12);
                    imm12 = r[11:0];
                    if (f3 == 3'b001) begin
                        imm12 = {7'b0, imm12[4:0]};
                    end else if (f3 == 3'b101) begin
                        imm12 = {1'b0, alt, 5'b0, imm12[4:0]};
                    end
                    imem[n] = {imm12, rs1, f3, rd, 7'b0010011};
                end
                3'd5: begin
                    r       = rand_bits(20);
                    imem[n] = {r[19:0], rd, 7'b0110111};
                end
                3'd6: begin
                    // lw rd, off(x0) inside the 64-word region
                    r       = rand_bits(6);
                    imem[n] = {4'b0, r[5:0], 2'b00, 5'd0, 3'b010, rd, 7'b0000011};
                end
                default: begin
                    r       = rand_bits(6);
                    imm12   = {4'b0, r[5:0], 2'b00};
                    imem[n] = {imm12[11:5], rs2, 5'd0, 3'b010, imm12[4:0], 7'b0100011};
                end
            endcase
            n++;
        end
        // dump x1..x31 to words 33..63
        for (int i = 1; i < 32; i++) begin
            imm12   = 12'(128 + 4 * i);
            imem[n] = {imm12[11:5], 5'(i), 5'd0, 3'b010, imm12[4:0], 7'b0100011};
            n++;
        end
    endtask

    task automatic model_step(input logic [31:0] w, input int idx);
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        logic [31:0] a;
        logic [31:0] res;
        logic [31:0] addr;
        logic        wr;
        rd   = w[11:7];
        f3   = w[14:12];
        rs1  = w[19:15];
        rs2  = w[24:20];
        a    = mregs[rs1];
        res  = '0;
        addr = '0;
        wr   = 1'b0;
        case (w[6:0])
            7'b0110011: begin
                res = alu_ref(f3, w[30], a, mregs[rs2]);
                wr  = 1'b1;
            end
            7'b0010011: begin
                // bit 30 is only a funct7 bit for shifts right
                res = alu_ref(f3, w[30] && (f3 == 3'b101), a, {{20{w[31]}}, w[31:20]});
                wr  = 1'b1;
            end
            7'b0110111: begin
                res = {w[31:12], 12'b0};
                wr  = 1'b1;
            end
            7'b0000011: begin
                addr = a + {{20{w[31]}}, w[31:20]};
                res  = mmem[addr[7:2]];
                wr   = 1'b1;
            end
            7'b0100011: begin
                addr              = a + {{20{w[31]}}, w[31:25], w[11:7]};
                mmem[addr[7:2]]   = mregs[rs2];
                exp_addr_q.push_back(addr);
                exp_data_q.push_back(mregs[rs2]);
                if (idx >= PROG_LEN - 31) begin
                    exp_name_q.push_back($sformatf("reg_dump_x%0d", rs2));
                end else begin
                    exp_name_q.push_back($sformatf("program_store_%0d", idx));
                end
            end
            default: ;
        endcase
        // x0 never changes
        if (wr && (rd != 5'd0)) begin
            mregs[rd] = res;
        end
    endtask

    // one-cycle memories
    always @(posedge clk) begin
        instr_mem_rdata_i <= imem[instr_mem_address_o[10:2]];
        if (data_write_o) begin
            dmem[data_mem_address_o[7:2]] <= data_mem_wdata_o;
        end
        if (data_read_o) begin
            data_mem_rdata_i <= dmem[data_mem_address_o[7:2]];
        end
    end

    // stores must match the model stream in order
    always @(posedge clk) begin
        if (rst_n_i && data_write_o) begin
            assert (exp_addr_q.size() > 0)
                else fail_run("a store appeared after the expected stream had ended");
            if (exp_addr_q.size() > 0) begin
                assert (data_mem_address_o == exp_addr_q[0])
                    else report_mismatch({exp_name_q[0], " addr"}, exp_addr_q[0],
                                         data_mem_address_o);
                assert (data_mem_wdata_o == exp_data_q[0])
                    else report_mismatch({exp_name_q[0], " data"}, exp_data_q[0],
                                         data_mem_wdata_o);
                void'(exp_addr_q.pop_front());
                void'(exp_data_q.pop_front());
                void'(exp_name_q.pop_front());
                stores_seen <= stores_seen + 1;
            end
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        fail_run("watchdog timeout, the expected stores did not all appear");
    end

    initial begin
        clk               = 1'b0;
        rst_n_i           = 1'b0;
        instr_mem_rdata_i = '0;
        data_mem_rdata_i  = '0;
        stores_seen       = 0;
        lfsr_state        = 32'hc36d2532;
        init_memories();
        build_program();
        for (int k = 0; k < PROG_LEN; k++) begin
            model_step(imem[k], k);
        end
        stores_total = exp_addr_q.size();

        // strobes are defined from the second reset cycle on
        for (int i = 0; i < 16; i++) begin
            @(posedge clk);
            if (i > 0) begin
                assert (!data_read_o && !data_write_o)
                    else fail_run("a data strobe was high during reset");
            end
        end
        rst_n_i <= 1'b1;
        @(posedge clk);
        assert (instr_mem_address_o == 32'd0)
            else report_mismatch("reset_fetch_addr", 32'd0, instr_mem_address_o);

        while (stores_seen < stores_total) begin
            @(posedge clk);
        end
        // a few idle cycles to catch stray stores
        repeat (10) @(posedge clk);
        $display("TEST PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: src.f
design/rv32i_pkg.sv
design/pipe_pkg.sv
design/bypass_if.sv
design/reg_file.sv
design/fetch_stage.sv
design/decode_stage.sv
design/execute_stage.sv
design/mem_wb_stage.sv
design/core_top.sv
verif/core_sva.sv
verif/core_tb.sv

// File: Makefile
LOG := sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -j 0 --top-module core_tb -f src.f -o Vcore_tb

run: build
	./obj_dir/Vcore_tb > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then exit 1; fi
	@grep -q "TEST PASSED" $(LOG)

lint:
	verilator --lint-only -Wall --timing --assert --top-module core_tb -f src.f

clean:
	rm -rf obj_dir $(LOG)
